// ==== design/cart_defines.svh ====
`ifndef CART_DEFINES_SVH
`define CART_DEFINES_SVH

////////////////////////////////////////
// load stream widths
////////////////////////////////////////

// byte address of a rom word
`define CART_ADDR_W 25
// one rom word per handshake
`define CART_WORD_W 16

////////////////////////////////////////
// header word addresses
////////////////////////////////////////

// product code spans five words
`define CART_ID_FIRST 25'h182
`define CART_ID_LAST  25'h18A
// first word past the code, lookup happens here
`define CART_ID_DONE  25'h18C
// region letters or hex region code
`define CART_RGN_A    25'h1F0
`define CART_RGN_B    25'h1F2
// header fully received once this word arrives
`define CART_HDR_END  25'h200

// sensor delay for anything that is not a known gun title
`define CART_GUN_DELAY_DEF 8'd44

`endif

// ==== design/load_pkg.sv ====
`default_nettype none

`include "cart_defines.svh"

package load_pkg;

	////////////////////////////////////////
	// rom word stream from the loader
	////////////////////////////////////////

	// byte address, words land on even addresses
	typedef logic [`CART_ADDR_W-1:0] load_addr_t;

	// byte view of one rom word
	typedef struct packed {
		logic [`CART_WORD_W/2-1:0] hi;
		logic [`CART_WORD_W/2-1:0] lo;
	} load_bytes_t;

	// a load word, taken whole or split into its two bytes
	// region letters read the bytes as they are
	// product code reads them swapped, lo first
	typedef union packed {
		logic [`CART_WORD_W-1:0] word;
		load_bytes_t             bytes;
	} load_word_u;

endpackage

`default_nettype wire

// ==== design/cart_pkg.sv ====
`default_nettype none

package cart_pkg;

	////////////////////////////////////////
	// console region
	////////////////////////////////////////

	// jp and us run ntsc timing, eu runs pal
	typedef enum logic [1:0] {
		rgn_jp = 2'd0,
		rgn_us = 2'd1,
		rgn_eu = 2'd2
	} region_e;

	// regions the header allows, one bit each
	typedef struct packed {
		logic j;
		logic u;
		logic e;
	} region_flags_t;

	// order in which allowed regions are tried
	typedef enum logic [1:0] {
		us_eu_jp = 2'd0,
		eu_us_jp = 2'd1,
		us_jp_eu = 2'd2,
		jp_us_eu = 2'd3
	} prio_e;

	////////////////////////////////////////
	// per title compatibility
	////////////////////////////////////////

	// at most one flag set per cartridge
	typedef struct packed {
		logic sram;
		logic sram00;
		logic eeprom;
		logic fifo;
		logic noram;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
	} quirk_t;

	// light gun model and sensor offset in pixels
	typedef struct packed {
		logic       gun_type;
		logic [7:0] sensor_delay;
	} gun_t;

endpackage

`default_nettype wire

// ==== design/load_word_if.sv ====
`default_nettype none
`timescale 1ns/1ns

// accepted load words, fanned out to both scanners
interface load_word_if import load_pkg::*; ();

	// one cycle per accepted word
	logic       word_stb;
	// address and data of that word, held until the next one
	load_addr_t addr;
	load_word_u data;
	// download frame edges, one cycle each
	logic       dl_start;
	logic       dl_end;

	// handshake side
	modport src (
		output word_stb,
		output addr,
		output data,
		output dl_start,
		output dl_end
	);

	// scanner side
	modport dst (
		input word_stb,
		input addr,
		input data,
		input dl_start,
		input dl_end
	);

endinterface

`default_nettype wire

// ==== design/load_port.sv ====
`default_nettype none
`timescale 1ns/1ns

module load_port import load_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       load_active,
	input  logic       load_req,
	input  load_addr_t load_addr,
	input  load_word_u load_data,
	output logic       load_ack,
	load_word_if.src   words,
	output load_addr_t rom_size
);

	// last sampled level of the download frame
	logic       active_q;
	// end of the current word, candidate rom size
	load_addr_t next_size;

	assign next_size = words.addr + load_addr_t'(2);

	////////////////////////////////////////
	// four-phase handshake
	////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			load_ack       <= 1'b0;
			words.word_stb <= 1'b0;
		end else begin
			// ack trails req by one cycle, both ways
			load_ack       <= load_req;
			// req high with ack still low is a fresh word
			words.word_stb <= load_req & ~load_ack;
		end
	end

	// word captured on the same edge that raises ack
	always_ff @(posedge clk_sys) begin
		if (load_req && !load_ack) begin
			words.addr <= load_addr;
			words.data <= load_data;
		end
	end

	////////////////////////////////////////
	// download framing
	////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			active_q       <= 1'b0;
			words.dl_start <= 1'b0;
			words.dl_end   <= 1'b0;
		end else begin
			active_q       <= load_active;
			words.dl_start <= load_active & ~active_q;
			words.dl_end   <= ~load_active & active_q;
		end
	end

	// highest accepted word plus one word, restarts with every download
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rom_size <= '0;
		end else if (words.dl_start) begin
			rom_size <= '0;
		end else if (words.word_stb && next_size > rom_size) begin
			rom_size <= next_size;
		end
	end

	// loader keeps req up until it has seen ack
	ack_needs_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(load_ack) |-> load_req);

	// loader frames every word inside load_active
	stb_in_frame: assert property (@(posedge clk_sys) disable iff (!rst_n)
		words.word_stb |-> load_active);

endmodule

`default_nettype wire

// ==== design/region_scan.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cart_defines.svh"

module region_scan import load_pkg::*, cart_pkg::*; (
	input  logic          clk_sys,
	input  logic          rst_n,
	load_word_if.dst      words,
	output region_flags_t flags
);

	// byte view of the current word
	load_bytes_t   rgn_bytes;
	// hex region code, bit0 jp, bit2 us, bit3 eu
	logic [3:0]    code_val;
	region_flags_t flags_nxt;

	// J, U or E adds its region, any other byte is ignored
	function automatic region_flags_t add_letter(region_flags_t f, logic [7:0] c);
		region_flags_t r;
		r = f;
		case (c)
			"J": r.j = 1'b1;
			"U": r.u = 1'b1;
			"E": r.e = 1'b1;
			default: ;
		endcase
		return r;
	endfunction

	assign rgn_bytes = words.data.bytes;

	always_comb begin
		flags_nxt = flags;
		// digits carry the value in the low nibble, A-F need 7 taken off
		code_val  = rgn_bytes.lo[3:0];
		if (rgn_bytes.lo >= "A" && rgn_bytes.lo <= "F") begin
			code_val = rgn_bytes.lo[3:0] - 4'd7;
		end

		if (words.addr == `CART_RGN_A) begin
			if (rgn_bytes.lo inside {"J", "U", "E"}) begin
				flags_nxt = add_letter(flags_nxt, rgn_bytes.lo);
			end else if ((rgn_bytes.lo >= "0" && rgn_bytes.lo <= "9") ||
				(rgn_bytes.lo >= "A" && rgn_bytes.lo <= "F")) begin
				// hex code bits add to whatever was collected so far
				flags_nxt.j = flags_nxt.j | code_val[0];
				flags_nxt.u = flags_nxt.u | code_val[2];
				flags_nxt.e = flags_nxt.e | code_val[3];
			end
			// high byte may still name a region letter
			flags_nxt = add_letter(flags_nxt, rgn_bytes.hi);
		end

		// second region word, low byte letters only
		if (words.addr == `CART_RGN_B) flags_nxt = add_letter(flags_nxt, rgn_bytes.lo);
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			flags <= '0;
		end else if (words.dl_start) begin
			flags <= '0;
		end else if (words.word_stb) begin
			flags <= flags_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== design/cart_id_match.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cart_defines.svh"

module cart_id_match import load_pkg::*, cart_pkg::*; (
	input  logic     clk_sys,
	input  logic     rst_n,
	load_word_if.dst words,
	output quirk_t   quirks,
	output gun_t     gun
);

	localparam gun_t GUN_DEFAULT = '{gun_type: 1'b0, sensor_delay: `CART_GUN_DELAY_DEF};

	// 8 ascii characters, first character in the top byte
	logic [63:0] cart_id;
	load_bytes_t id_bytes;
	// middle words carry two characters, low byte first
	logic [15:0] id_swap;
	quirk_t      quirk_nxt;
	gun_t        gun_nxt;

	assign id_bytes = words.data.bytes;
	assign id_swap  = {id_bytes.lo, id_bytes.hi};

	////////////////////////////////////////
	// product code assembly
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (words.word_stb) begin
			case (words.addr)
				`CART_ID_FIRST:          cart_id[63:56] <= id_bytes.hi;
				`CART_ID_FIRST + 25'd2:  cart_id[55:40] <= id_swap;
				`CART_ID_FIRST + 25'd4:  cart_id[39:24] <= id_swap;
				`CART_ID_FIRST + 25'd6:  cart_id[23:8]  <= id_swap;
				`CART_ID_LAST:           cart_id[7:0]   <= id_bytes.lo;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// title table
	////////////////////////////////////////

	always_comb begin
		quirk_nxt = '0;
		case (cart_id)
			// battery ram on odd bytes
			"T-081276", "T-81406 ": quirk_nxt.sram = 1'b1;
			" GM 0000": quirk_nxt.sram00 = 1'b1;
			// serial eeprom saves
			"MK-1215 ", "G-4060  ": quirk_nxt.eeprom = 1'b1;
			"T-89016 ": quirk_nxt.fifo = 1'b1;
			// puggsy, fake ram check must fail
			"T-113016": quirk_nxt.noram = 1'b1;
			"T-574023": quirk_nxt.pier = 1'b1;
			// virtua racing dsp cart
			"MK-1229 ", "G-7001  ": quirk_nxt.svp = 1'b1;
			"T-35036 ": quirk_nxt.fmbusy = 1'b1;
			"T-68???-": quirk_nxt.schan = 1'b1;
			default: ;
		endcase

		// gun model and timing offset per title
		gun_nxt = GUN_DEFAULT;
		case (cart_id)
			"MK-1533 ": gun_nxt = '{gun_type: 1'b0, sensor_delay: 8'd100};
			"T-95096-": gun_nxt = '{gun_type: 1'b1, sensor_delay: 8'd52};
			"T-95136-": gun_nxt = '{gun_type: 1'b1, sensor_delay: 8'd30};
			"MK-1658 ": gun_nxt = '{gun_type: 1'b0, sensor_delay: 8'd120};
			"T-081156": gun_nxt = '{gun_type: 1'b0, sensor_delay: 8'd126};
			default: ;
		endcase
	end

	// lookup result taken once the whole code is in
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			quirks <= '0;
			gun    <= GUN_DEFAULT;
		end else if (words.dl_start) begin
			quirks <= '0;
			gun    <= GUN_DEFAULT;
		end else if (words.word_stb && words.addr == `CART_ID_DONE) begin
			quirks <= quirk_nxt;
			gun    <= gun_nxt;
		end
	end

	// the console model only supports one quirk at a time
	quirk_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot0(quirks));

endmodule

`default_nettype wire

// ==== design/cart_profile.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cart_defines.svh"

module cart_profile import cart_pkg::*; (
	input  logic          clk_sys,
	input  logic          rst_n,
	load_word_if.dst      words,
	input  region_flags_t flags,
	input  quirk_t        quirks_in,
	input  gun_t          gun_in,
	input  prio_e         rgn_priority,
	output region_e       region,
	output logic          pal,
	output quirk_t        quirks,
	output gun_t          gun,
	output logic          profile_valid
);

	// header end word arrived in this download
	logic    hdr_seen;
	region_e rgn_nxt;

	// first allowed region in priority order, us when the header allows none
	function automatic region_e pick_region(region_flags_t f, prio_e p);
		region_e r;
		r = rgn_us;
		case (p)
			us_eu_jp: begin
				if (f.u) r = rgn_us;
				else if (f.e) r = rgn_eu;
				else if (f.j) r = rgn_jp;
			end
			eu_us_jp: begin
				if (f.e) r = rgn_eu;
				else if (f.u) r = rgn_us;
				else if (f.j) r = rgn_jp;
			end
			us_jp_eu: begin
				if (f.u) r = rgn_us;
				else if (f.j) r = rgn_jp;
				else if (f.e) r = rgn_eu;
			end
			jp_us_eu: begin
				if (f.j) r = rgn_jp;
				else if (f.u) r = rgn_us;
				else if (f.e) r = rgn_eu;
			end
		endcase
		return r;
	endfunction

	assign rgn_nxt = pick_region(flags, rgn_priority);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			hdr_seen      <= 1'b0;
			region        <= rgn_us;
			pal           <= 1'b0;
			quirks        <= '0;
			gun           <= '{gun_type: 1'b0, sensor_delay: `CART_GUN_DELAY_DEF};
			profile_valid <= 1'b0;
		end else begin
			if (words.dl_start) begin
				hdr_seen      <= 1'b0;
				profile_valid <= 1'b0;
			end else if (words.word_stb && words.addr == `CART_HDR_END) begin
				hdr_seen <= 1'b1;
			end
			// a cut off download keeps the previous profile and stays invalid
			if (words.dl_end && hdr_seen) begin
				region        <= rgn_nxt;
				pal           <= (rgn_nxt == rgn_eu);
				quirks        <= quirks_in;
				gun           <= gun_in;
				profile_valid <= 1'b1;
			end
		end
	end

	// valid drops before the first word of a new download lands
	valid_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		words.word_stb |-> !profile_valid);

endmodule

`default_nettype wire

// ==== design/cart_scan_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module cart_scan_top import load_pkg::*, cart_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	// loader side
	input  logic       load_active,
	input  logic       load_req,
	input  load_addr_t load_addr,
	input  load_word_u load_data,
	input  prio_e      rgn_priority,
	output logic       load_ack,
	// cartridge profile
	output load_addr_t rom_size,
	output region_e    region,
	output logic       pal,
	output quirk_t     quirks,
	output gun_t       gun,
	output logic       profile_valid
);

	// scanner results into the profile block
	region_flags_t rgn_flags;
	quirk_t        id_quirks;
	gun_t          id_gun;

	load_word_if words ();

	////////////////////////////////////////
	// handshake and framing
	////////////////////////////////////////

	load_port load_port_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.load_active (load_active),
		.load_req    (load_req),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.load_ack    (load_ack),
		.words       (words.src),
		.rom_size    (rom_size)
	);

	////////////////////////////////////////
	// header scanners
	////////////////////////////////////////

	region_scan region_scan_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.words   (words.dst),
		.flags   (rgn_flags)
	);

	cart_id_match cart_id_match_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.words   (words.dst),
		.quirks  (id_quirks),
		.gun     (id_gun)
	);

	// region resolve and end of download latch
	cart_profile cart_profile_i (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.words         (words.dst),
		.flags         (rgn_flags),
		.quirks_in     (id_quirks),
		.gun_in        (id_gun),
		.rgn_priority  (rgn_priority),
		.region        (region),
		.pal           (pal),
		.quirks        (quirks),
		.gun           (gun),
		.profile_valid (profile_valid)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_cart_scan.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "cart_defines.svh"

module tb_cart_scan import load_pkg::*, cart_pkg::*; ();

	// cycles allowed for each handshake edge
	localparam int ACK_TIMEOUT     = 16;
	// cycles allowed from end of download to a latched profile
	localparam int PROFILE_TIMEOUT = 8;

	logic       clk_sys;
	logic       rst_n;
	logic       load_active;
	logic       load_req;
	load_addr_t load_addr;
	load_word_u load_data;
	prio_e      rgn_priority;
	logic       load_ack;
	load_addr_t rom_size;
	region_e    region;
	logic       pal;
	quirk_t     quirks;
	gun_t       gun;
	logic       profile_valid;

	// words of the current cartridge record, in file order
	load_addr_t addr_q[$];
	load_word_u data_q[$];

	int checks;
	int value_errs;
	int other_errs;
	int records;

	cart_scan_top cart_scan_top_i (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.load_active   (load_active),
		.load_req      (load_req),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.rgn_priority  (rgn_priority),
		.load_ack      (load_ack),
		.rom_size      (rom_size),
		.region        (region),
		.pal           (pal),
		.quirks        (quirks),
		.gun           (gun),
		.profile_valid (profile_valid)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			value_errs++;
			$display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_region(input string name, input region_e got, input region_e exp);
		checks++;
		if (got !== exp) begin
			value_errs++;
			$display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_quirks(input string name, input quirk_t got, input quirk_t exp);
		checks++;
		if (got !== exp) begin
			value_errs++;
			$display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_gun(input string name, input gun_t got, input gun_t exp);
		checks++;
		if (got !== exp) begin
			value_errs++;
			$display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input load_addr_t got, input load_addr_t exp);
		checks++;
		if (got !== exp) begin
			value_errs++;
			$display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	////////////////////////////////////////
	// loader model
	////////////////////////////////////////

	// ack sampled on falling edges, away from the dut update
	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (load_ack !== level && n < ACK_TIMEOUT);
		if (load_ack !== level) begin
			other_errs++;
			$display("load_ack did not go %s within %0d cycles", level ? "high" : "low",
				ACK_TIMEOUT);
		end
	endtask

	// one full four-phase transfer plus a random idle gap
	task automatic send_word(input load_addr_t a, input load_word_u d);
		@(posedge clk_sys);
		load_addr <= a;
		load_data <= d;
		load_req  <= 1'b1;
		wait_ack(1'b1);
		@(posedge clk_sys);
		load_req <= 1'b0;
		wait_ack(1'b0);
		repeat ($urandom % 4) @(posedge clk_sys);
	endtask

	// profile_valid polled after the frame closes
	task automatic wait_profile(input logic exp_valid);
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (profile_valid !== 1'b1 && n < PROFILE_TIMEOUT);
		if (exp_valid && profile_valid !== 1'b1) begin
			other_errs++;
			$display("profile_valid did not rise within %0d cycles after the download",
				PROFILE_TIMEOUT);
		end else if (!exp_valid && profile_valid === 1'b1) begin
			other_errs++;
			$display("profile_valid rose after a download without a complete header");
		end
	endtask

	// framed download of the queued words, then the profile checks
	task automatic run_record(input prio_e p, input region_e exp_rgn, input logic exp_pal,
		input quirk_t exp_q, input gun_t exp_g, input load_addr_t exp_size,
		input logic exp_valid);
		@(posedge clk_sys);
		rgn_priority <= p;
		load_active  <= 1'b1;
		// frame start clears the scanners, keep words clear of it
		repeat (3) @(posedge clk_sys);
		foreach (addr_q[i]) begin
			send_word(addr_q[i], data_q[i]);
		end
		@(posedge clk_sys);
		load_active <= 1'b0;
		wait_profile(exp_valid);
		check_region("region", region, exp_rgn);
		check_bit("pal", pal, exp_pal);
		check_quirks("quirks", quirks, exp_q);
		check_gun("gun", gun, exp_g);
		check_addr("rom_size", rom_size, exp_size);
		check_bit("profile_valid", profile_valid, exp_valid);
		records++;
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		int          fd;
		int          n;
		string       line;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [31:0] f4;
		logic [31:0] f5;
		logic [31:0] f6;
		prio_e       cur_prio;
		gun_t        exp_gun;

		checks       = 0;
		value_errs   = 0;
		other_errs   = 0;
		records      = 0;
		cur_prio     = us_eu_jp;
		void'($urandom(32'hb104_432d));
		rst_n        = 1'b0;
		load_active  = 1'b0;
		load_req     = 1'b0;
		load_addr    = '0;
		load_data    = '0;
		rgn_priority = us_eu_jp;

		repeat (10) @(posedge clk_sys);
		rst_n <= 1'b1;

		// reset state of the profile outputs
		@(negedge clk_sys);
		exp_gun = '{gun_type: 1'b0, sensor_delay: `CART_GUN_DELAY_DEF};
		check_bit("load_ack", load_ack, 1'b0);
		check_bit("profile_valid", profile_valid, 1'b0);
		check_quirks("quirks", quirks, '0);
		check_region("region", region, rgn_us);
		check_gun("gun", gun, exp_gun);

		fd = $fopen("testbench/cart_golden.txt", "r");
		if (fd == 0) begin
			other_errs++;
			$display("could not open testbench/cart_golden.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() == 0) continue;
				case (line.getc(0))
					// new cartridge, priority mode first
					"C": begin
						n = $sscanf(line, "C %h", f0);
						cur_prio = prio_e'(f0[1:0]);
						addr_q.delete();
						data_q.delete();
					end
					"W": begin
						n = $sscanf(line, "W %h %h", f0, f1);
						addr_q.push_back(load_addr_t'(f0));
						data_q.push_back(load_word_u'(f1[15:0]));
					end
					// expect line closes the record
					"X": begin
						n = $sscanf(line, "X %h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6);
						if (n != 7) begin
							other_errs++;
							$display("malformed expect line in the golden file");
						end else begin
							exp_gun = '{gun_type: f3[0], sensor_delay: f4[7:0]};
							run_record(cur_prio, region_e'(f0[1:0]), f1[0], quirk_t'(f2[8:0]),
								exp_gun, load_addr_t'(f5), f6[0]);
						end
					end
					default: ;
				endcase
			end
			$fclose(fd);
		end

		if (records == 0) begin
			other_errs++;
			$display("no cartridge records were run");
		end

		$display("records %0d, checks %0d, value errors %0d, other errors %0d",
			records, checks, value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/load_pkg.sv
design/cart_pkg.sv
design/load_word_if.sv
design/load_port.sv
design/region_scan.sv
design/cart_id_match.sv
design/cart_profile.sv
design/cart_scan_top.sv
testbench/tb_cart_scan.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the cartridge scan testbench with verilator and run it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ns -f sim.f \
	--top-module tb_cart_scan -j 0 \
	&& ./obj_dir/Vtb_cart_scan > sim.log 2>&1 \
	|| { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "Testbench passed" sim.log && exit 0 || exit 1

// ==== testbench/cart_golden.txt ====
# C prio | W addr data | X region pal quirks gun_type gun_delay rom_size valid, all hex
# prio 0 us_eu_jp 1 eu_us_jp 2 us_jp_eu 3 jp_us_eu, region 0 jp 1 us 2 eu
# T-081276 sram, letters U and E, eu first
C 1
W 182 5420
W 184 302D
W 186 3138
W 188 3732
W 18A 2036
W 18C 2020
W 1F0 5545
W 200 0000
W 3FE FFFF
X 2 1 100 0 2C 400 1
# cut off before the header end, previous profile holds
C 0
W 182 4D20
W 1FE 1234
X 2 1 100 0 2C 200 0
# T-95096- gun title, J in the second region word
C 2
W 182 5420
W 184 392D
W 186 3035
W 188 3639
W 18A 202D
W 18C 2020
W 1F0 2020
W 1F2 204A
W 200 0000
W 100 1111
X 0 0 000 1 34 202 1
# unknown code, region digit 8
C 0
W 182 4120
W 184 4342
W 186 4544
W 188 4746
W 18A 2048
W 18C 2020
W 1F0 2038
W 200 0000
W 7FFE 0000
X 2 1 000 0 2C 8000 1
# T-35036 fmbusy, region code C
C 3
W 182 5420
W 184 332D
W 186 3035
W 188 3633
W 18A 2020
W 18C 2020
W 1F0 2043
W 200 0000
X 1 0 002 0 2C 202 1
# MK-1533 gun title, no region words
C 1
W 182 4D20
W 184 2D4B
W 186 3531
W 188 3333
W 18A 2020
W 18C 2020
W 200 0000
X 1 0 000 0 64 202 1
